// File: common/ramio_params.svh
//--------------------------------------------------------------------------
// build-time constants for the RAM and I/O bridge
// port addresses, RAM size and UART bit period, included where needed
//--------------------------------------------------------------------------
`ifndef RAMIO_PARAMS_SVH
`define RAMIO_PARAMS_SVH

// memory-mapped I/O ports, one 32-bit word each
// led port, active low nibble
`define RAMIO_ADDR_LED 32'hffff_fffc
// transmit port, reads back the byte in flight
`define RAMIO_ADDR_UART_OUT 32'hffff_fff8
// receive port, cleared by a read
`define RAMIO_ADDR_UART_IN 32'hffff_fff4

// log2 of RAM depth in 32-bit words
`define RAMIO_RAM_DEPTH_LOG2 8

// clocks per UART bit, kept small so a frame is short in simulation
`define RAMIO_CLKS_PER_BIT 8

// idle transmitter / empty receiver read value
`define RAMIO_IDLE_WORD 32'hffff_ffff

`endif

// File: common/ramio_pkg.sv
//--------------------------------------------------------------------------
// shared types of the RAM and I/O bridge
// referenced by scoped name from every module and the request interface
//--------------------------------------------------------------------------
package ramio_pkg;

  // client byte address
  typedef logic [31:0] addr_t;
  // client and RAM data word
  typedef logic [31:0] data_t;
  // one enable per byte lane
  typedef logic [3:0] byte_en_t;
  // byte lane within a word
  typedef logic [1:0] lane_t;
  // bit 2 sign extend, low bits 01 byte, 10 half word, 11 word
  typedef logic [2:0] read_type_t;
  // same size code as the read type, zero is no write
  typedef logic [1:0] write_type_t;
  // led nibble, 0 lights the led
  typedef logic [3:0] led_t;
  typedef logic [7:0] uart_byte_t;

  // decoded I/O port of a request
  typedef enum logic [1:0] {
    io_none,
    io_led,
    io_uart_out,
    io_uart_in
  } io_port_e;

  // serializer FSM
  typedef enum logic [1:0] {
    tx_idle,
    tx_start,
    tx_data,
    tx_stop
  } tx_state_e;

  // deserializer FSM
  typedef enum logic [1:0] {
    rx_idle,
    rx_start,
    rx_data,
    rx_stop
  } rx_state_e;

endpackage

// File: common/bus_req_if.sv
//--------------------------------------------------------------------------
// decoded client request, driven by the decoder and seen by the RAM
// and the I/O register block side by side
//--------------------------------------------------------------------------
`timescale 1ns/100ps

interface bus_req_if;

  // aligned RAM access
  logic                 ram_sel;
  ramio_pkg::io_port_e  io_port;
  logic                 rd;
  logic                 wr;
  // byte address shifted down to a word index
  ramio_pkg::addr_t     word_addr;
  ramio_pkg::byte_en_t  byte_en;
  // write data already moved to its lane
  ramio_pkg::data_t     wdata;

  modport decoder (output ram_sel, io_port, rd, wr, word_addr, byte_en, wdata);
  modport ram (input ram_sel, rd, wr, word_addr, byte_en, wdata);
  modport io (input io_port, rd, wr, wdata);

endinterface

// File: hw/access_decode.sv
//--------------------------------------------------------------------------
// request decoder, splits each client access into RAM, I/O or ignored
// builds byte enables and lane-shifted write data for the RAM
//--------------------------------------------------------------------------
`timescale 1ns/100ps
`include "ramio_params.svh"

module access_decode (
  input  logic                   enable,
  input  ramio_pkg::addr_t       address,
  input  ramio_pkg::read_type_t  read_type,
  input  ramio_pkg::write_type_t write_type,
  input  ramio_pkg::data_t       data_in,
  bus_req_if.decoder             req,
  output logic                   io_hit,
  output logic                   misaligned,
  output ramio_pkg::lane_t       lane
);

  logic                access;
  logic [1:0]          size;
  ramio_pkg::io_port_e port;

  always_comb begin
    lane = address[1:0];
    req.rd = enable && (read_type[1:0] != 2'b00);
    req.wr = enable && (write_type != 2'b00);
    access = req.rd || req.wr;
    // a request never reads and writes at once, so one size code applies
    size = req.rd ? read_type[1:0] : write_type;

    // exact match on the three port words
    case (address)
      `RAMIO_ADDR_LED:      port = ramio_pkg::io_led;
      `RAMIO_ADDR_UART_OUT: port = ramio_pkg::io_uart_out;
      `RAMIO_ADDR_UART_IN:  port = ramio_pkg::io_uart_in;
      default:              port = ramio_pkg::io_none;
    endcase
    io_hit = access && (port != ramio_pkg::io_none);
    req.io_port = io_hit ? port : ramio_pkg::io_none;

    // half word needs an even lane, word needs lane 0
    misaligned = access && !io_hit &&
                 ((size == 2'b10 && lane[0]) || (size == 2'b11 && lane != 2'b00));
    req.ram_sel = access && !io_hit && !misaligned;

    // byte enables follow size and lane
    case (size)
      2'b01:   req.byte_en = 4'b0001 << lane;
      2'b10:   req.byte_en = 4'b0011 << lane;
      2'b11:   req.byte_en = 4'b1111;
      default: req.byte_en = 4'b0000;
    endcase
    req.wdata = data_in << {lane, 3'b000};
    req.word_addr = {2'b00, address[31:2]};
  end

  // RAM and I/O selects are exclusive for every address
  always_comb begin
    assert (!(req.ram_sel && req.io_port != ramio_pkg::io_none))
      else $error("RAM and I/O port selected together");
  end

endmodule

// File: hw/word_ram.sv
//--------------------------------------------------------------------------
// synchronous word RAM with per-lane writes and a registered read
// read data is valid the cycle after an addressed ram_sel read
//--------------------------------------------------------------------------
`timescale 1ns/100ps
`include "ramio_params.svh"

module word_ram #(
  parameter int depth_log2 = `RAMIO_RAM_DEPTH_LOG2
) (
  input  logic             clk,
  bus_req_if.ram           req,
  output ramio_pkg::data_t ram_rdata
);

  ramio_pkg::data_t        mem [2**depth_log2];
  logic [depth_log2-1:0]   index;

  // upper word address bits alias onto the array
  assign index = req.word_addr[depth_log2-1:0];

  always_ff @(posedge clk) begin
    if (req.ram_sel && req.wr) begin
      for (int i = 0; i < 4; i++) begin
        if (req.byte_en[i]) begin
          mem[index][i*8 +: 8] <= req.wdata[i*8 +: 8];
        end
      end
    end
    // re-registered each cycle of a held read
    if (req.ram_sel && req.rd) begin
      ram_rdata <= mem[index];
    end
  end

  // the decoder never raises both strobes
  assert property (@(posedge clk) !(req.rd && req.wr))
    else $error("read and write in one request");

endmodule

// File: hw/read_combiner.sv
//--------------------------------------------------------------------------
// read path and client handshake
// merges RAM and I/O read data, aligns and extends the lane,
// and holds one wait cycle for every RAM read
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module read_combiner (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  enable,
  input  ramio_pkg::read_type_t read_type,
  input  logic                  ram_sel,
  input  logic                  io_hit,
  input  logic                  misaligned,
  input  ramio_pkg::lane_t      lane,
  input  ramio_pkg::data_t      ram_rdata,
  input  ramio_pkg::data_t      io_rdata,
  output ramio_pkg::data_t      data_out,
  output logic                  busy,
  output logic                  data_out_ready
);

  logic             is_read;
  logic             pending;
  ramio_pkg::data_t lane_data;

  assign is_read = read_type[1:0] != 2'b00;
  // first cycle of a RAM read waits for the registered word
  assign busy = ram_sel && is_read && !pending;
  assign data_out_ready = enable && !busy;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pending <= 1'b0;
    end else if (data_out_ready) begin
      pending <= 1'b0;
    end else if (busy) begin
      pending <= 1'b1;
    end
  end

  always_comb begin
    // addressed lane moved down to bit 0
    lane_data = ram_rdata >> {lane, 3'b000};
    data_out = '0;
    if (!is_read || misaligned) begin
      data_out = '0;
    end else if (io_hit) begin
      data_out = io_rdata;
    end else if (ram_sel) begin
      case (read_type[1:0])
        2'b01: data_out = {{24{read_type[2] & lane_data[7]}}, lane_data[7:0]};
        2'b10: data_out = {{16{read_type[2] & lane_data[15]}}, lane_data[15:0]};
        default: data_out = ram_rdata;
      endcase
    end
  end

  // the client holds its request through the wait cycle of a RAM read
  assert property (@(posedge clk) disable iff (!rst_n) pending |-> enable)
    else $error("enable dropped during a RAM read wait");

endmodule

// File: io/uart_tx.sv
//--------------------------------------------------------------------------
// 8N1 UART serializer
// a rising tx_go starts a frame, tx_busy stays high to the stop bit's end
//--------------------------------------------------------------------------
`timescale 1ns/100ps
`include "ramio_params.svh"

module uart_tx (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  tx_go,
  input  ramio_pkg::uart_byte_t tx_data,
  output logic                  tx_busy,
  output logic                  txd
);

  localparam int cnt_w = $clog2(`RAMIO_CLKS_PER_BIT);
  localparam logic [cnt_w-1:0] baud_last = cnt_w'(`RAMIO_CLKS_PER_BIT - 1);

  ramio_pkg::tx_state_e  state;
  logic [cnt_w-1:0]      baud_cnt;
  logic [2:0]            bit_cnt;
  ramio_pkg::uart_byte_t shift;
  // go seen last cycle, only an edge starts a frame
  logic                  go_q;

  assign tx_busy = state != ramio_pkg::tx_idle;

  always_comb begin
    case (state)
      ramio_pkg::tx_start: txd = 1'b0;
      ramio_pkg::tx_data:  txd = shift[0];
      default:             txd = 1'b1;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= ramio_pkg::tx_idle;
      baud_cnt <= '0;
      bit_cnt <= '0;
      go_q <= 1'b0;
    end else begin
      go_q <= tx_go;
      baud_cnt <= (state == ramio_pkg::tx_idle || baud_cnt == baud_last) ? '0 : baud_cnt + 1'b1;
      case (state)
        ramio_pkg::tx_idle: begin
          if (tx_go && !go_q) begin
            shift <= tx_data;
            state <= ramio_pkg::tx_start;
          end
        end
        ramio_pkg::tx_start: begin
          bit_cnt <= '0;
          if (baud_cnt == baud_last) state <= ramio_pkg::tx_data;
        end
        ramio_pkg::tx_data: begin
          // lsb first
          if (baud_cnt == baud_last) begin
            shift <= shift >> 1;
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) state <= ramio_pkg::tx_stop;
          end
        end
        default: begin
          if (baud_cnt == baud_last) state <= ramio_pkg::tx_idle;
        end
      endcase
    end
  end

endmodule

// File: io/uart_rx.sv
//--------------------------------------------------------------------------
// 8N1 UART deserializer, bits sampled at their middle
// rx_valid holds with the byte until the consumer pulses rx_ack
//--------------------------------------------------------------------------
`timescale 1ns/100ps
`include "ramio_params.svh"

module uart_rx (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  rxd,
  input  logic                  rx_ack,
  output logic                  rx_valid,
  output ramio_pkg::uart_byte_t rx_byte
);

  localparam int cnt_w = $clog2(`RAMIO_CLKS_PER_BIT);
  localparam logic [cnt_w-1:0] baud_last = cnt_w'(`RAMIO_CLKS_PER_BIT - 1);
  localparam logic [cnt_w-1:0] baud_half = cnt_w'(`RAMIO_CLKS_PER_BIT / 2 - 1);

  ramio_pkg::rx_state_e  state;
  logic [1:0]            rxd_sync;
  logic [cnt_w-1:0]      baud_cnt;
  logic [2:0]            bit_cnt;
  ramio_pkg::uart_byte_t shift;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      // line idles high
      rxd_sync <= 2'b11;
      state <= ramio_pkg::rx_idle;
      baud_cnt <= '0;
      bit_cnt <= '0;
      rx_valid <= 1'b0;
    end else begin
      rxd_sync <= {rxd_sync[0], rxd};
      baud_cnt <= baud_cnt + 1'b1;
      if (rx_ack) rx_valid <= 1'b0;
      case (state)
        ramio_pkg::rx_idle: begin
          baud_cnt <= '0;
          if (!rxd_sync[1]) state <= ramio_pkg::rx_start;
        end
        ramio_pkg::rx_start: begin
          // recheck at half bit, later samples then fall mid-bit
          if (baud_cnt == baud_half) begin
            baud_cnt <= '0;
            bit_cnt <= '0;
            state <= rxd_sync[1] ? ramio_pkg::rx_idle : ramio_pkg::rx_data;
          end
        end
        ramio_pkg::rx_data: begin
          if (baud_cnt == baud_last) begin
            shift <= {rxd_sync[1], shift[7:1]};
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) state <= ramio_pkg::rx_stop;
          end
        end
        default: begin
          // bad stop bit drops the frame, an unread byte is overwritten
          if (baud_cnt == baud_last) begin
            if (rxd_sync[1]) begin
              rx_byte <= shift;
              rx_valid <= 1'b1;
            end
            state <= ramio_pkg::rx_idle;
          end
        end
      endcase
    end
  end

endmodule

// File: io/io_regs.sv
//--------------------------------------------------------------------------
// memory-mapped I/O registers, leds and both UART ports
// writes and read side effects take place at the completing clock edge
//--------------------------------------------------------------------------
`timescale 1ns/100ps
`include "ramio_params.svh"

module io_regs (
  input  logic             clk,
  input  logic             rst_n,
  bus_req_if.io            req,
  output ramio_pkg::data_t io_rdata,
  output ramio_pkg::led_t  led,
  output logic             uart_tx,
  input  logic             uart_rx
);

  ramio_pkg::data_t      tx_word;
  ramio_pkg::data_t      rx_word;
  logic                  tx_go;
  logic                  tx_busy;
  logic                  tx_busy_q;
  logic                  rx_valid;
  logic                  rx_ack;
  ramio_pkg::uart_byte_t rx_byte;

  // led port reads zero
  always_comb begin
    case (req.io_port)
      ramio_pkg::io_uart_out: io_rdata = tx_word;
      ramio_pkg::io_uart_in:  io_rdata = rx_word;
      default:                io_rdata = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      led <= 4'b1111;
      tx_word <= `RAMIO_IDLE_WORD;
      tx_go <= 1'b0;
      tx_busy_q <= 1'b0;
      rx_word <= `RAMIO_IDLE_WORD;
      rx_ack <= 1'b0;
    end else begin
      tx_busy_q <= tx_busy;
      if (req.wr && req.io_port == ramio_pkg::io_led) begin
        led <= req.wdata[3:0];
      end
      // end of frame, back to idle
      // a write landing in this same cycle is dropped
      if (tx_busy_q && !tx_busy) begin
        tx_go <= 1'b0;
        tx_word <= `RAMIO_IDLE_WORD;
      end else if (req.wr && req.io_port == ramio_pkg::io_uart_out) begin
        // overwrites a byte still in flight
        tx_word <= {24'h0, req.wdata[7:0]};
        tx_go <= 1'b1;
      end
      // read clears first, a byte arriving now still lands
      if (req.rd && req.io_port == ramio_pkg::io_uart_in) begin
        rx_word <= `RAMIO_IDLE_WORD;
      end
      rx_ack <= rx_valid && !rx_ack;
      if (rx_valid && !rx_ack) begin
        rx_word <= {24'h0, rx_byte};
      end
    end
  end

  uart_tx uart_tx_i (
    .clk, .rst_n, .tx_go, .tx_data(tx_word[7:0]), .tx_busy, .txd(uart_tx)
  );

  uart_rx uart_rx_i (
    .clk, .rst_n, .rxd(uart_rx), .rx_ack, .rx_valid, .rx_byte
  );

endmodule

// File: hw/ramio_top.sv
//--------------------------------------------------------------------------
// RAM and I/O access bridge top level
// client request in, read data and handshake out, leds and UART pins
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module ramio_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   enable,
  input  ramio_pkg::read_type_t  read_type,
  input  ramio_pkg::write_type_t write_type,
  input  ramio_pkg::addr_t       address,
  input  ramio_pkg::data_t       data_in,
  output ramio_pkg::data_t       data_out,
  output logic                   data_out_ready,
  output logic                   busy,
  output ramio_pkg::led_t        led,
  output logic                   uart_tx,
  input  logic                   uart_rx
);

  bus_req_if        req_if ();
  logic             io_hit;
  logic             misaligned;
  ramio_pkg::lane_t lane;
  ramio_pkg::data_t ram_rdata;
  ramio_pkg::data_t io_rdata;

  access_decode access_decode_i (
    .enable, .address, .read_type, .write_type, .data_in,
    .req(req_if.decoder), .io_hit, .misaligned, .lane
  );

  word_ram word_ram_i (.clk, .req(req_if.ram), .ram_rdata);

  io_regs io_regs_i (
    .clk, .rst_n, .req(req_if.io), .io_rdata, .led, .uart_tx, .uart_rx
  );

  // RAM select comes straight off the shared request
  read_combiner read_combiner_i (
    .clk, .rst_n, .enable, .read_type, .ram_sel(req_if.ram_sel), .io_hit,
    .misaligned, .lane, .ram_rdata, .io_rdata, .data_out, .busy, .data_out_ready
  );

endmodule

// File: sim/ramio_tb.sv
//--------------------------------------------------------------------------
// table-driven testbench for the RAM and I/O bridge
// RAM round trips, lane merges, extension, misalignment, leds and a UART
// loopback from the transmit pin back into the receive pin
//--------------------------------------------------------------------------
`timescale 1ns/100ps
`include "ramio_params.svh"

module ramio_tb;

  localparam int op_wr = 0;
  localparam int op_rd = 1;
  // re-read while the port still returns the value in the data column
  localparam int op_poll = 2;
  // compare the led pins with the low nibble of the expected column
  localparam int op_led = 3;

  logic                   clk;
  logic                   rst_n;
  logic                   enable;
  ramio_pkg::read_type_t  read_type;
  ramio_pkg::write_type_t write_type;
  ramio_pkg::addr_t       address;
  ramio_pkg::data_t       data_in;
  ramio_pkg::data_t       data_out;
  logic                   data_out_ready;
  logic                   busy;
  ramio_pkg::led_t        led;
  // transmit pin looped straight back to the receive pin
  logic                   serial;

  // stimulus table, entry i of every queue makes up row i
  string                  row_name[$];
  int                     row_op[$];
  ramio_pkg::addr_t       row_addr[$];
  ramio_pkg::read_type_t  row_code[$];
  ramio_pkg::data_t       row_wdata[$];
  ramio_pkg::data_t       row_exp[$];

  int                     cycles = 0;
  int                     limit;
  ramio_pkg::data_t       word_a;
  ramio_pkg::data_t       word_b;
  ramio_pkg::data_t       rdata;

  ramio_top ramio_top_i (
    .clk, .rst_n, .enable, .read_type, .write_type, .address, .data_in,
    .data_out, .data_out_ready, .busy, .led, .uart_tx(serial), .uart_rx(serial)
  );

  always #5 clk = ~clk;

  // ------------------------------------------------------------------------
  // watchdog
  // ------------------------------------------------------------------------
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= limit) begin
      $display("timeout after %0d cycles, the DUT stopped completing requests", cycles);
      $display("CHECKS FAILED");
      $fatal(1, "run aborted by the watchdog");
    end
  end

  task automatic add_row(input string name, input int op, input ramio_pkg::addr_t addr,
                         input ramio_pkg::read_type_t code, input ramio_pkg::data_t wdata,
                         input ramio_pkg::data_t exp);
    row_name.push_back(name);
    row_op.push_back(op);
    row_addr.push_back(addr);
    row_code.push_back(code);
    row_wdata.push_back(wdata);
    row_exp.push_back(exp);
  endtask

  task automatic check_data(input string name, input ramio_pkg::data_t exp,
                            input ramio_pkg::data_t act);
    if (act !== exp) begin
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
      $display("CHECKS FAILED");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic check_led(input string name, input ramio_pkg::led_t exp,
                           input ramio_pkg::led_t act);
    if (act !== exp) begin
      $display("[FAIL] %s expected %b actual %b", name, exp, act);
      $display("CHECKS FAILED");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  // handshake outputs, busy and data_out_ready
  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[FAIL] %s expected %b actual %b", name, exp, act);
      $display("CHECKS FAILED");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  // aligned RAM reads wait one cycle, I/O, misaligned and writes complete at once
  function automatic logic ram_read_waits(input int op, input ramio_pkg::addr_t addr,
                                          input ramio_pkg::read_type_t code);
    logic io_addr;
    logic aligned;
    io_addr = (addr == `RAMIO_ADDR_LED) || (addr == `RAMIO_ADDR_UART_OUT) ||
              (addr == `RAMIO_ADDR_UART_IN);
    case (code[1:0])
      2'b10:   aligned = !addr[0];
      2'b11:   aligned = addr[1:0] == 2'b00;
      default: aligned = 1'b1;
    endcase
    return (op != op_wr) && !io_addr && aligned;
  endfunction

  // one request, driven on the falling edge and held until data_out_ready
  task automatic do_access(input string name, input int op, input ramio_pkg::addr_t addr,
                           input ramio_pkg::read_type_t code, input ramio_pkg::data_t wdata,
                           output ramio_pkg::data_t result);
    logic done;
    logic wait_cycle;
    done = 1'b0;
    wait_cycle = ram_read_waits(op, addr, code);
    @(negedge clk);
    enable = 1'b1;
    address = addr;
    data_in = wdata;
    read_type = (op == op_wr) ? 3'b000 : code;
    write_type = (op == op_wr) ? code[1:0] : 2'b00;
    while (!done) begin
      // outputs are settled well inside the low phase
      #2;
      check_flag({name, " busy"}, wait_cycle, busy);
      check_flag({name, " data_out_ready"}, !wait_cycle, data_out_ready);
      done = data_out_ready;
      result = data_out;
      // at most the first cycle waits
      wait_cycle = 1'b0;
      @(posedge clk);
      if (!done) @(negedge clk);
    end
    // request completed at that edge, drop it before the next one
    @(negedge clk);
    enable = 1'b0;
  endtask

  task automatic fill_table();
    // leds first, while the reset value is still in place
    add_row("led_reset", op_led, 32'h0, 3'b000, 32'h0, 32'h0000_000f);
    add_row("led_write", op_wr, `RAMIO_ADDR_LED, 3'b011, 32'h0000_0005, 32'h0);
    add_row("led_after_write", op_led, 32'h0, 3'b000, 32'h0, 32'h0000_0005);
    add_row("led_port_read", op_rd, `RAMIO_ADDR_LED, 3'b011, 32'h0, 32'h0);
    // word round trips at both ends of the RAM
    add_row("word_a_wr", op_wr, 32'h0000_0010, 3'b011, word_a, 32'h0);
    add_row("word_b_wr", op_wr, 32'h0000_03fc, 3'b011, word_b, 32'h0);
    add_row("word_a_rd", op_rd, 32'h0000_0010, 3'b011, 32'h0, word_a);
    add_row("word_b_rd", op_rd, 32'h0000_03fc, 3'b011, 32'h0, word_b);
    // 11223344 -> byte aa in lane 1 -> half beef in lanes 2 and 3
    add_row("merge_base", op_wr, 32'h0000_0020, 3'b011, 32'h1122_3344, 32'h0);
    add_row("merge_byte", op_wr, 32'h0000_0021, 3'b001, 32'h0000_00aa, 32'h0);
    add_row("merge_half", op_wr, 32'h0000_0022, 3'b010, 32'h0000_beef, 32'h0);
    add_row("merge_rd", op_rd, 32'h0000_0020, 3'b011, 32'h0, 32'hbeef_aa44);
    // lanes hold 01, 7f, ff, 80 from low to high
    add_row("ext_base", op_wr, 32'h0000_0030, 3'b011, 32'h80ff_7f01, 32'h0);
    add_row("ext_b0_u", op_rd, 32'h0000_0030, 3'b001, 32'h0, 32'h0000_0001);
    add_row("ext_b0_s", op_rd, 32'h0000_0030, 3'b101, 32'h0, 32'h0000_0001);
    add_row("ext_b1_u", op_rd, 32'h0000_0031, 3'b001, 32'h0, 32'h0000_007f);
    add_row("ext_b1_s", op_rd, 32'h0000_0031, 3'b101, 32'h0, 32'h0000_007f);
    add_row("ext_b2_u", op_rd, 32'h0000_0032, 3'b001, 32'h0, 32'h0000_00ff);
    add_row("ext_b2_s", op_rd, 32'h0000_0032, 3'b101, 32'h0, 32'hffff_ffff);
    add_row("ext_b3_u", op_rd, 32'h0000_0033, 3'b001, 32'h0, 32'h0000_0080);
    add_row("ext_b3_s", op_rd, 32'h0000_0033, 3'b101, 32'h0, 32'hffff_ff80);
    add_row("ext_h0_u", op_rd, 32'h0000_0030, 3'b010, 32'h0, 32'h0000_7f01);
    add_row("ext_h0_s", op_rd, 32'h0000_0030, 3'b110, 32'h0, 32'h0000_7f01);
    add_row("ext_h2_u", op_rd, 32'h0000_0032, 3'b010, 32'h0, 32'h0000_80ff);
    add_row("ext_h2_s", op_rd, 32'h0000_0032, 3'b110, 32'h0, 32'hffff_80ff);
    // misaligned writes are dropped, misaligned reads give zero
    add_row("mis_word_wr", op_wr, 32'h0000_0032, 3'b011, 32'hdead_beef, 32'h0);
    add_row("mis_half_wr", op_wr, 32'h0000_0031, 3'b010, 32'h0000_1234, 32'h0);
    add_row("mis_unchanged", op_rd, 32'h0000_0030, 3'b011, 32'h0, 32'h80ff_7f01);
    add_row("mis_half_rd", op_rd, 32'h0000_0033, 3'b110, 32'h0, 32'h0);
    add_row("mis_word_rd", op_rd, 32'h0000_0031, 3'b011, 32'h0, 32'h0);
    // UART loopback
    add_row("tx_idle", op_rd, `RAMIO_ADDR_UART_OUT, 3'b011, 32'h0, `RAMIO_IDLE_WORD);
    add_row("tx_send", op_wr, `RAMIO_ADDR_UART_OUT, 3'b011, 32'h0000_005a, 32'h0);
    add_row("tx_sending", op_rd, `RAMIO_ADDR_UART_OUT, 3'b011, 32'h0, 32'h0000_005a);
    add_row("rx_poll", op_poll, `RAMIO_ADDR_UART_IN, 3'b011, `RAMIO_IDLE_WORD,
            32'h0000_005a);
    add_row("rx_cleared", op_rd, `RAMIO_ADDR_UART_IN, 3'b011, 32'h0, `RAMIO_IDLE_WORD);
    add_row("tx_done", op_poll, `RAMIO_ADDR_UART_OUT, 3'b011, 32'h0000_005a,
            `RAMIO_IDLE_WORD);
  endtask

  // ------------------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------------------
  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    enable = 1'b0;
    read_type = '0;
    write_type = '0;
    address = '0;
    data_in = '0;
    word_a = $urandom(24);
    word_b = $urandom();
    fill_table();
    // four cycles a row plus three UART frames
    limit = row_name.size() * 4 + 3 * 10 * `RAMIO_CLKS_PER_BIT + 100;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    for (int i = 0; i < row_name.size(); i++) begin
      case (row_op[i])
        op_wr: begin
          do_access(row_name[i], op_wr, row_addr[i], row_code[i], row_wdata[i], rdata);
        end
        op_rd: begin
          do_access(row_name[i], op_rd, row_addr[i], row_code[i], '0, rdata);
          check_data(row_name[i], row_exp[i], rdata);
        end
        op_poll: begin
          // bounded by the watchdog
          rdata = row_wdata[i];
          while (rdata === row_wdata[i]) begin
            do_access(row_name[i], op_rd, row_addr[i], row_code[i], '0, rdata);
          end
          check_data(row_name[i], row_exp[i], rdata);
        end
        default: begin
          @(negedge clk);
          #2;
          rdata = row_exp[i];
          check_led(row_name[i], rdata[3:0], led);
        end
      endcase
    end
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// File: compile.f
+incdir+common
common/ramio_pkg.sv
common/bus_req_if.sv
hw/access_decode.sv
hw/word_ram.sv
hw/read_combiner.sv
io/uart_tx.sv
io/uart_rx.sv
io/io_regs.sv
hw/ramio_top.sv
sim/ramio_tb.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing -sv -f compile.f --top-module ramio_tb
status=0
out=$(./obj_dir/Vramio_tb 2>&1) || status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ] || ! printf '%s\n' "$out" | grep -qx 'ALL CHECKS PASSED'; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"
